//--- logic/cpuPkg.sv
// ************************************************
// shared types and ISA field layout of the core
// modules take it with a wildcard import in the body
// ************************************************
`default_nettype none

package cpuPkg;

    // opcode, register index, shamt and ALU op fields are all this wide
    localparam int fieldWidth = 5;
    localparam int immWidth = 17;
    localparam int targetWidth = 27;

    // lsb position of each instruction field
    localparam int opPos = 27;
    localparam int rdPos = 22;
    localparam int rsPos = 17;
    localparam int rtPos = 12;
    localparam int shamtPos = 7;
    localparam int aluOpPos = 2;

    typedef logic [31:0] word_t;
    typedef logic [fieldWidth-1:0] regIdx_t;

    typedef enum logic [fieldWidth-1:0] {
        opRtype = 5'd0,
        opJ     = 5'd1,
        opBne   = 5'd2,
        opJal   = 5'd3,
        opJr    = 5'd4,
        opAddi  = 5'd5,
        opBlt   = 5'd6,
        opSw    = 5'd7,
        opLw    = 5'd8
    } opcode_t;

    typedef enum logic [fieldWidth-1:0] {
        aluAdd = 5'd0,
        aluSub = 5'd1,
        aluAnd = 5'd2,
        aluOr  = 5'd3,
        aluSll = 5'd4,
        aluSra = 5'd5
    } aluOp_t;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        fwdRf = 2'd0,
        fwdXm = 2'd1,
        fwdMw = 2'd2
    } fwdSel_t;

    // return address register of jal
    localparam regIdx_t linkReg = 5'd31;

endpackage

`default_nettype wire

//--- logic/fetchStage.sv
// ************************************************
// program counter and the fetch/decode register
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module fetchStage #(
    parameter cpuPkg::word_t resetPc = '0
) (
    input  logic          clock,
    input  logic          rst,
    input  logic          stall,
    input  logic          redirect,
    input  cpuPkg::word_t redirectPc,
    output cpuPkg::word_t imemAddr,
    input  cpuPkg::word_t imemData,
    output cpuPkg::word_t fdInstr,
    output cpuPkg::word_t fdPc
);
    import cpuPkg::*;

    word_t pc;

    // imem answers for this address in the same cycle
    assign imemAddr = pc;

    // redirect wins over a load-use stall
    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= resetPc;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!stall) begin
            pc <= pc + word_t'(1);
        end
    end

    // the word fetched under a redirect is wrong path
    // zero decodes as add r0, r0, r0
    always_ff @(posedge clock) begin
        if (rst || redirect) begin
            fdInstr <= '0;
        end else if (!stall) begin
            fdInstr <= imemData;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fdPc <= pc;
        end
    end

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
// ************************************************
// instruction decode, register read select and the
// decode/execute register, bubbles on stall or flush
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
    input  logic            clock,
    input  logic            rst,
    input  cpuPkg::word_t   fdInstr,
    input  cpuPkg::word_t   fdPc,
    input  logic            stall,
    input  logic            flush,
    output cpuPkg::regIdx_t rfReadA,
    output cpuPkg::regIdx_t rfReadB,
    input  cpuPkg::word_t   rfDataA,
    input  cpuPkg::word_t   rfDataB,
    output cpuPkg::word_t   dxPc,
    output cpuPkg::word_t   dxValA,
    output cpuPkg::word_t   dxValB,
    output cpuPkg::word_t   dxImm,
    output cpuPkg::word_t   dxTarget,
    output cpuPkg::regIdx_t dxRegA,
    output cpuPkg::regIdx_t dxRegB,
    output cpuPkg::regIdx_t dxDest,
    output cpuPkg::aluOp_t  dxAluOp,
    output logic [4:0]      dxShamt,
    output logic            dxUseImm,
    output logic            dxRegWrite,
    output logic            dxMemRead,
    output logic            dxMemWrite,
    output logic            dxBranchNe,
    output logic            dxBranchLt,
    output logic            dxJump,
    output logic            dxJumpReg,
    output logic            dxLink
);
    import cpuPkg::*;

    opcode_t opcode;
    regIdx_t rd, rs, rt;
    aluOp_t aluOp;
    logic useImm, regWrite, memRead, memWrite;
    logic branchNe, branchLt, jump, jumpReg, link;

    // field split
    assign opcode = opcode_t'(fdInstr[opPos +: fieldWidth]);
    assign rd = fdInstr[rdPos +: fieldWidth];
    assign rs = fdInstr[rsPos +: fieldWidth];
    assign rt = fdInstr[rtPos +: fieldWidth];

    // control decode, unknown opcodes do nothing
    always_comb begin
        aluOp = aluAdd;
        useImm = 1'b0;
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        branchNe = 1'b0;
        branchLt = 1'b0;
        jump = 1'b0;
        jumpReg = 1'b0;
        link = 1'b0;
        case (opcode)
            opRtype: begin
                aluOp = aluOp_t'(fdInstr[aluOpPos +: fieldWidth]);
                regWrite = 1'b1;
            end
            opAddi: begin
                useImm = 1'b1;
                regWrite = 1'b1;
            end
            opLw: begin
                useImm = 1'b1;
                regWrite = 1'b1;
                memRead = 1'b1;
            end
            opSw: begin
                useImm = 1'b1;
                memWrite = 1'b1;
            end
            opBne: branchNe = 1'b1;
            opBlt: branchLt = 1'b1;
            opJ: jump = 1'b1;
            opJal: begin
                jump = 1'b1;
                link = 1'b1;
                regWrite = 1'b1;
            end
            opJr: jumpReg = 1'b1;
            default: ;
        endcase
    end

    // branches compare rd against rs
    // sw stores rd and jr jumps to rd, both through port B
    assign rfReadA = (branchNe || branchLt) ? rd : rs;
    assign rfReadB = (branchNe || branchLt) ? rs : (memWrite || jumpReg) ? rd : rt;

    // control half of the decode/execute register
    always_ff @(posedge clock) begin
        if (rst || stall || flush) begin
            dxRegA <= '0;
            dxRegB <= '0;
            dxDest <= '0;
            dxUseImm <= 1'b0;
            dxRegWrite <= 1'b0;
            dxMemRead <= 1'b0;
            dxMemWrite <= 1'b0;
            dxBranchNe <= 1'b0;
            dxBranchLt <= 1'b0;
            dxJump <= 1'b0;
            dxJumpReg <= 1'b0;
            dxLink <= 1'b0;
        end else begin
            dxRegA <= rfReadA;
            dxRegB <= rfReadB;
            dxDest <= link ? linkReg : rd;
            dxUseImm <= useImm;
            dxRegWrite <= regWrite;
            dxMemRead <= memRead;
            dxMemWrite <= memWrite;
            dxBranchNe <= branchNe;
            dxBranchLt <= branchLt;
            dxJump <= jump;
            dxJumpReg <= jumpReg;
            dxLink <= link;
        end
    end

    // payload half, only meaningful behind valid controls
    always_ff @(posedge clock) begin
        dxPc <= fdPc;
        dxValA <= rfDataA;
        dxValB <= rfDataB;
        dxAluOp <= aluOp;
        dxShamt <= fdInstr[shamtPos +: fieldWidth];
        // sign-extend the immediate, zero-pad the jump target
        dxImm <= word_t'($signed(fdInstr[immWidth-1:0]));
        dxTarget <= word_t'(fdInstr[targetWidth-1:0]);
    end

endmodule

`default_nettype wire

//--- logic/regFile.sv
// ************************************************
// 32x32 register file, r0 reads zero
// reads see a write to the same register in that cycle
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic            clock,
    input  logic            rst,
    input  cpuPkg::regIdx_t rfReadA,
    input  cpuPkg::regIdx_t rfReadB,
    output cpuPkg::word_t   rfDataA,
    output cpuPkg::word_t   rfDataB,
    input  logic            rfWriteEnable,
    input  cpuPkg::regIdx_t rfWriteReg,
    input  cpuPkg::word_t   rfWriteData
);
    import cpuPkg::*;

    // r0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rfWriteEnable && rfWriteReg != '0) begin
            regs[rfWriteReg] <= rfWriteData;
        end
    end

    // zero for r0, writeback data on a same-cycle hit
    function automatic word_t readPort(regIdx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (rfWriteEnable && rfWriteReg == idx) begin
            return rfWriteData;
        end
        return regs[idx];
    endfunction

    assign rfDataA = readPort(rfReadA);
    assign rfDataB = readPort(rfReadB);

endmodule

`default_nettype wire

//--- logic/hazardUnit.sv
// ************************************************
// forwarding selects for the ALU operands and the
// one-cycle load-use stall
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  cpuPkg::regIdx_t rfReadA,
    input  cpuPkg::regIdx_t rfReadB,
    input  cpuPkg::regIdx_t dxRegA,
    input  cpuPkg::regIdx_t dxRegB,
    input  cpuPkg::regIdx_t dxDest,
    input  cpuPkg::regIdx_t xmDest,
    input  cpuPkg::regIdx_t rfWriteReg,
    input  logic            dxMemRead,
    input  logic            xmRegWrite,
    input  logic            rfWriteEnable,
    output cpuPkg::fwdSel_t fwdA,
    output cpuPkg::fwdSel_t fwdB,
    output logic            stall
);
    import cpuPkg::*;

    // memory stage is younger than writeback, so it wins
    // r0 never forwards
    function automatic fwdSel_t pickSource(regIdx_t src);
        if (src == '0) begin
            return fwdRf;
        end
        if (xmRegWrite && xmDest == src) begin
            return fwdXm;
        end
        if (rfWriteEnable && rfWriteReg == src) begin
            return fwdMw;
        end
        return fwdRf;
    endfunction

    assign fwdA = pickSource(dxRegA);
    assign fwdB = pickSource(dxRegB);

    // load data only exists after the memory stage
    // so a consumer right behind a load waits one cycle
    assign stall = dxMemRead && dxDest != '0
                   && (dxDest == rfReadA || dxDest == rfReadB);

endmodule

`default_nettype wire

//--- logic/executeStage.sv
// ************************************************
// operand forwarding, ALU, branch and jump resolution
// and the execute/memory register
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module executeStage (
    input  logic            clock,
    input  logic            rst,
    input  cpuPkg::word_t   dxPc,
    input  cpuPkg::word_t   dxValA,
    input  cpuPkg::word_t   dxValB,
    input  cpuPkg::word_t   dxImm,
    input  cpuPkg::word_t   dxTarget,
    input  cpuPkg::regIdx_t dxDest,
    input  cpuPkg::aluOp_t  dxAluOp,
    input  logic [4:0]      dxShamt,
    input  logic            dxUseImm,
    input  logic            dxRegWrite,
    input  logic            dxMemRead,
    input  logic            dxMemWrite,
    input  logic            dxBranchNe,
    input  logic            dxBranchLt,
    input  logic            dxJump,
    input  logic            dxJumpReg,
    input  logic            dxLink,
    input  cpuPkg::fwdSel_t fwdA,
    input  cpuPkg::fwdSel_t fwdB,
    input  cpuPkg::word_t   rfWriteData,
    output logic            redirect,
    output cpuPkg::word_t   redirectPc,
    output cpuPkg::word_t   xmResult,
    output cpuPkg::word_t   xmStoreData,
    output cpuPkg::regIdx_t xmDest,
    output logic            xmRegWrite,
    output logic            xmMemRead,
    output logic            xmMemWrite
);
    import cpuPkg::*;

    word_t opA, opB, aluB, aluOut, pcPlus1, branchTarget;
    logic taken;

    function automatic word_t pickOperand(fwdSel_t sel, word_t rfVal, word_t xmVal,
                                          word_t mwVal);
        case (sel)
            fwdXm: return xmVal;
            fwdMw: return mwVal;
            default: return rfVal;
        endcase
    endfunction

    // xmResult is this stage's own register output
    assign opA = pickOperand(fwdA, dxValA, xmResult, rfWriteData);
    assign opB = pickOperand(fwdB, dxValB, xmResult, rfWriteData);
    assign aluB = dxUseImm ? dxImm : opB;

    // shifts move operand A by shamt
    always_comb begin
        case (dxAluOp)
            aluAdd: aluOut = opA + aluB;
            aluSub: aluOut = opA - aluB;
            aluAnd: aluOut = opA & aluB;
            aluOr: aluOut = opA | aluB;
            aluSll: aluOut = opA << dxShamt;
            aluSra: aluOut = word_t'($signed(opA) >>> dxShamt);
            default: aluOut = '0;
        endcase
    end

    assign pcPlus1 = dxPc + word_t'(1);
    assign branchTarget = pcPlus1 + dxImm;

    // A holds rd and B holds rs for branches
    assign taken = (dxBranchNe && opA != opB)
                   || (dxBranchLt && $signed(opA) < $signed(opB));
    assign redirect = taken || dxJump || dxJumpReg;

    // jr target comes through port B
    assign redirectPc = dxJumpReg ? opB : dxJump ? dxTarget : branchTarget;

    always_ff @(posedge clock) begin
        if (rst) begin
            xmDest <= '0;
            xmRegWrite <= 1'b0;
            xmMemRead <= 1'b0;
            xmMemWrite <= 1'b0;
        end else begin
            xmDest <= dxDest;
            xmRegWrite <= dxRegWrite;
            xmMemRead <= dxMemRead;
            xmMemWrite <= dxMemWrite;
        end
    end

    // jal links PC+1, everything else takes the ALU
    always_ff @(posedge clock) begin
        xmResult <= dxLink ? pcPlus1 : aluOut;
        xmStoreData <= opB;
    end

endmodule

`default_nettype wire

//--- logic/memWriteback.sv
// ************************************************
// data memory drive, memory/writeback register
// and the register file write port
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module memWriteback (
    input  logic            clock,
    input  logic            rst,
    input  cpuPkg::word_t   xmResult,
    input  cpuPkg::word_t   xmStoreData,
    input  cpuPkg::regIdx_t xmDest,
    input  logic            xmRegWrite,
    input  logic            xmMemRead,
    input  logic            xmMemWrite,
    output cpuPkg::word_t   dmemAddr,
    output cpuPkg::word_t   dmemWdata,
    output logic            dmemWren,
    input  cpuPkg::word_t   dmemRdata,
    output logic            rfWriteEnable,
    output cpuPkg::regIdx_t rfWriteReg,
    output cpuPkg::word_t   rfWriteData
);
    import cpuPkg::*;

    // ALU result is the address for lw and sw
    assign dmemAddr = xmResult;
    assign dmemWdata = xmStoreData;
    assign dmemWren = xmMemWrite;

    always_ff @(posedge clock) begin
        if (rst) begin
            rfWriteEnable <= 1'b0;
            rfWriteReg <= '0;
        end else begin
            rfWriteEnable <= xmRegWrite;
            rfWriteReg <= xmDest;
        end
    end

    // load data is valid within the memory cycle
    always_ff @(posedge clock) begin
        rfWriteData <= xmMemRead ? dmemRdata : xmResult;
    end

endmodule

`default_nettype wire

//--- logic/cpuCore.sv
// ************************************************
// five-stage pipelined core, memories stay outside
// instruction and data memories answer in the same cycle
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module cpuCore #(
    parameter cpuPkg::word_t resetPc = '0
) (
    input  logic          clock,
    input  logic          rst,
    output cpuPkg::word_t imemAddr,
    input  cpuPkg::word_t imemData,
    output cpuPkg::word_t dmemAddr,
    output cpuPkg::word_t dmemWdata,
    output logic          dmemWren,
    input  cpuPkg::word_t dmemRdata
);
    import cpuPkg::*;

    // fetch to decode
    word_t fdInstr, fdPc;
    // register file read side
    regIdx_t rfReadA, rfReadB;
    word_t rfDataA, rfDataB;
    // decode to execute
    word_t dxPc, dxValA, dxValB, dxImm, dxTarget;
    regIdx_t dxRegA, dxRegB, dxDest;
    aluOp_t dxAluOp;
    logic [4:0] dxShamt;
    logic dxUseImm, dxRegWrite, dxMemRead, dxMemWrite;
    logic dxBranchNe, dxBranchLt, dxJump, dxJumpReg, dxLink;
    // execute to memory
    word_t xmResult, xmStoreData;
    regIdx_t xmDest;
    logic xmRegWrite, xmMemRead, xmMemWrite;
    // writeback, also the fwdMw source
    logic rfWriteEnable;
    regIdx_t rfWriteReg;
    word_t rfWriteData;
    // hazard and control flow
    fwdSel_t fwdA, fwdB;
    logic stall, redirect;
    word_t redirectPc;

    fetchStage #(.resetPc(resetPc)) fetch_i (
        .clock, .rst, .stall, .redirect, .redirectPc,
        .imemAddr, .imemData, .fdInstr, .fdPc
    );

    // a redirect flushes the instruction in decode
    decodeStage decode_i (
        .clock, .rst, .fdInstr, .fdPc, .stall, .flush(redirect),
        .rfReadA, .rfReadB, .rfDataA, .rfDataB,
        .dxPc, .dxValA, .dxValB, .dxImm, .dxTarget,
        .dxRegA, .dxRegB, .dxDest, .dxAluOp, .dxShamt,
        .dxUseImm, .dxRegWrite, .dxMemRead, .dxMemWrite,
        .dxBranchNe, .dxBranchLt, .dxJump, .dxJumpReg, .dxLink
    );

    regFile regFile_i (
        .clock, .rst, .rfReadA, .rfReadB, .rfDataA, .rfDataB,
        .rfWriteEnable, .rfWriteReg, .rfWriteData
    );

    hazardUnit hazard_i (
        .rfReadA, .rfReadB, .dxRegA, .dxRegB, .dxDest, .xmDest, .rfWriteReg,
        .dxMemRead, .xmRegWrite, .rfWriteEnable, .fwdA, .fwdB, .stall
    );

    executeStage execute_i (
        .clock, .rst,
        .dxPc, .dxValA, .dxValB, .dxImm, .dxTarget, .dxDest, .dxAluOp, .dxShamt,
        .dxUseImm, .dxRegWrite, .dxMemRead, .dxMemWrite,
        .dxBranchNe, .dxBranchLt, .dxJump, .dxJumpReg, .dxLink,
        .fwdA, .fwdB, .rfWriteData, .redirect, .redirectPc,
        .xmResult, .xmStoreData, .xmDest, .xmRegWrite, .xmMemRead, .xmMemWrite
    );

    memWriteback memWb_i (
        .clock, .rst, .xmResult, .xmStoreData, .xmDest,
        .xmRegWrite, .xmMemRead, .xmMemWrite,
        .dmemAddr, .dmemWdata, .dmemWren, .dmemRdata,
        .rfWriteEnable, .rfWriteReg, .rfWriteData
    );

endmodule

`default_nettype wire

//--- bench/cpuCore_chk.sv
// ************************************************
// concurrent checks on the core's control signals
// bound into every cpuCore instance
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module cpuCoreChk (
    input logic          clock,
    input logic          rst,
    input logic          dmemWren,
    input logic          rfWriteEnable,
    input logic          stall,
    input logic          redirect,
    input cpuPkg::word_t imemAddr
);

    // one reset edge is enough to clear both write strobes
    resetQuiet: assert property (@(posedge clock)
        rst && $past(rst) |-> !dmemWren && !rfWriteEnable)
        else $error("store or register write while reset is held");

    // a load in execute can never be a branch or jump
    stallOrRedirect: assert property (@(posedge clock) disable iff (rst)
        !(stall && redirect))
        else $error("stall and redirect raised together");

    pcKnown: assert property (@(posedge clock) disable iff (rst)
        !$isunknown(imemAddr))
        else $error("instruction address has unknown bits");

endmodule

bind cpuCore cpuCoreChk chk_i (
    .clock(clock),
    .rst(rst),
    .dmemWren(dmemWren),
    .rfWriteEnable(rfWriteEnable),
    .stall(stall),
    .redirect(redirect),
    .imemAddr(imemAddr)
);

`default_nettype wire

//--- bench/cpuTb.sv
// ************************************************
// core testbench with memory models and an ISA model
// every data store is compared in order against the model
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module cpuTb;
    import cpuPkg::*;

    localparam word_t bootPc = '0;
    localparam int memWords = 256;
    localparam int cyclesPerInstr = 20;

    logic clock;
    logic rst;
    word_t imemAddr, dmemAddr, dmemWdata;
    word_t imemData = '0;
    word_t dmemRdata = '0;
    logic dmemWren;

    word_t progMem [0:memWords-1];
    word_t dataMem [0:memWords-1];
    int progLen = 0;
    // expected store stream from the ISA model
    word_t expAddr [$];
    word_t expData [$];
    int expCount = 0;
    int storeIdx = 0;
    int watchLimit = 0;

    cpuCore #(.resetPc(bootPc)) dut_i (
        .clock, .rst, .imemAddr, .imemData,
        .dmemAddr, .dmemWdata, .dmemWren, .dmemRdata
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic abortRun();
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
            abortRun();
        end
    endtask

    // uses every address bit, so misdirected loads show up
    function automatic word_t fillWord(int addr);
        return (word_t'(addr) * 32'h0001_0003) ^ 32'hc3a5_5a3c;
    endfunction

    function automatic word_t encodeR(aluOp_t op, regIdx_t rd, regIdx_t rs, regIdx_t rt,
                                      logic [4:0] shamt);
        return {opRtype, rd, rs, rt, shamt, op, 2'b00};
    endfunction

    function automatic word_t encodeI(opcode_t op, regIdx_t rd, regIdx_t rs, int imm);
        logic [16:0] immBits;
        immBits = imm[16:0];
        return {op, rd, rs, immBits};
    endfunction

    function automatic word_t encodeJ(opcode_t op, int target);
        logic [26:0] targetBits;
        targetBits = target[26:0];
        return {op, targetBits};
    endfunction

    // sw stores rd at rs + imm, base is always r0 here
    function automatic word_t encodeStore(regIdx_t src, int addr);
        return encodeI(opSw, src, 5'd0, addr);
    endfunction

    task automatic emit(input word_t instr);
        progMem[progLen] = instr;
        progLen++;
    endtask

    task automatic buildProgram();
        int here;
        int imm;
        regIdx_t rd, rs, rt;
        logic [4:0] sh;
        for (int i = 0; i < memWords; i++) begin
            progMem[i] = '0;
        end
        // dependent chain, forwarding from both stages
        emit(encodeI(opAddi, 5'd1, 5'd0, 5));
        emit(encodeI(opAddi, 5'd2, 5'd1, -3));
        emit(encodeR(aluAdd, 5'd3, 5'd1, 5'd2, 5'd0));
        emit(encodeR(aluSll, 5'd4, 5'd3, 5'd0, 5'd4));
        emit(encodeI(opAddi, 5'd6, 5'd0, -100));
        emit(encodeR(aluSra, 5'd5, 5'd6, 5'd0, 5'd2));
        emit(encodeR(aluSub, 5'd7, 5'd5, 5'd4, 5'd0));
        emit(encodeR(aluAnd, 5'd8, 5'd7, 5'd3, 5'd0));
        emit(encodeR(aluOr, 5'd9, 5'd8, 5'd4, 5'd0));
        emit(encodeStore(5'd9, 0));
        emit(encodeStore(5'd4, 1));
        emit(encodeStore(5'd5, 2));
        emit(encodeStore(5'd7, 3));
        // load-use, once through an ALU operand and once as store data
        emit(encodeI(opAddi, 5'd10, 5'd0, 64));
        emit(encodeI(opLw, 5'd11, 5'd10, 3));
        emit(encodeR(aluAdd, 5'd12, 5'd11, 5'd1, 5'd0));
        emit(encodeStore(5'd12, 4));
        emit(encodeI(opLw, 5'd13, 5'd0, 1));
        emit(encodeStore(5'd13, 5));
        // branches, each skips one store when taken
        emit(encodeI(opBne, 5'd1, 5'd1, 1));
        emit(encodeStore(5'd1, 6));
        emit(encodeI(opBne, 5'd1, 5'd2, 1));
        emit(encodeStore(5'd2, 7));
        emit(encodeI(opBlt, 5'd2, 5'd1, 1));
        emit(encodeStore(5'd3, 8));
        emit(encodeI(opBlt, 5'd1, 5'd2, 1));
        emit(encodeStore(5'd6, 9));
        emit(encodeI(opBlt, 5'd6, 5'd1, 1));
        emit(encodeStore(5'd5, 10));
        emit(encodeJ(opJ, progLen + 2));
        emit(encodeStore(5'd4, 11));
        // call and return, the subroutine sits past a jump
        here = progLen;
        emit(encodeJ(opJal, here + 3));
        emit(encodeStore(5'd31, 12));
        emit(encodeJ(opJ, here + 5));
        emit(encodeI(opAddi, 5'd14, 5'd0, 77));
        emit(encodeI(opJr, 5'd31, 5'd0, 0));
        emit(encodeStore(5'd14, 13));
        // random section, every result goes out through a store
        for (int k = 0; k < 40; k++) begin
            rd = regIdx_t'(1 + $urandom % 15);
            rs = regIdx_t'($urandom % 16);
            rt = regIdx_t'($urandom % 16);
            sh = 5'($urandom % 32);
            if ($urandom % 4 == 0) begin
                imm = int'($urandom % 131072) - 65536;
                emit(encodeI(opAddi, rd, rs, imm));
            end else begin
                emit(encodeR(aluOp_t'($urandom % 6), rd, rs, rt, sh));
            end
            emit(encodeStore(rd, 128 + k));
        end
        // park on a jump to itself
        emit(encodeJ(opJ, progLen));
    endtask

    // ISA model, fills the expected store queues
    // returns how many instructions ran
    function automatic int refRun();
        word_t regs [0:31];
        word_t mem [0:memWords-1];
        word_t pc, nextPc, instr, imm, addr, res;
        regIdx_t rd, rs, rt;
        logic [4:0] shamt;
        opcode_t op;
        logic halted;
        int steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < memWords; i++) begin
            mem[i] = fillWord(i);
        end
        pc = bootPc;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 10000) begin
            instr = (pc < word_t'(memWords)) ? progMem[pc[7:0]] : '0;
            op = opcode_t'(instr[31:27]);
            rd = instr[26:22];
            rs = instr[21:17];
            rt = instr[16:12];
            shamt = instr[11:7];
            imm = {{15{instr[16]}}, instr[16:0]};
            nextPc = pc + 1;
            steps++;
            case (op)
                opRtype: begin
                    case (aluOp_t'(instr[6:2]))
                        aluAdd: res = regs[rs] + regs[rt];
                        aluSub: res = regs[rs] - regs[rt];
                        aluAnd: res = regs[rs] & regs[rt];
                        aluOr: res = regs[rs] | regs[rt];
                        aluSll: res = regs[rs] << shamt;
                        aluSra: res = word_t'($signed(regs[rs]) >>> shamt);
                        default: res = '0;
                    endcase
                    regs[rd] = res;
                end
                opAddi: regs[rd] = regs[rs] + imm;
                opLw: begin
                    addr = regs[rs] + imm;
                    regs[rd] = (addr < word_t'(memWords)) ? mem[addr[7:0]] : '0;
                end
                opSw: begin
                    addr = regs[rs] + imm;
                    expAddr.push_back(addr);
                    expData.push_back(regs[rd]);
                    if (addr < word_t'(memWords)) begin
                        mem[addr[7:0]] = regs[rd];
                    end
                end
                // branches compare rd against rs
                opBne: if (regs[rd] != regs[rs]) nextPc = pc + 1 + imm;
                opBlt: if ($signed(regs[rd]) < $signed(regs[rs])) nextPc = pc + 1 + imm;
                opJ: begin
                    nextPc = {5'b0, instr[26:0]};
                    halted = (nextPc == pc);
                end
                opJal: begin
                    regs[31] = pc + 1;
                    nextPc = {5'b0, instr[26:0]};
                end
                opJr: nextPc = regs[rd];
                default: ;
            endcase
            // r0 stays zero whatever was written
            regs[0] = '0;
            pc = nextPc;
        end
        return steps;
    endfunction

    // memory models, a store lands before this cycle's read data
    always @(negedge clock) begin
        if (!rst && dmemWren && dmemAddr < word_t'(memWords)) begin
            dataMem[dmemAddr[7:0]] = dmemWdata;
        end
        imemData <= (imemAddr < word_t'(memWords)) ? progMem[imemAddr[7:0]] : '0;
        dmemRdata <= (dmemAddr < word_t'(memWords)) ? dataMem[dmemAddr[7:0]] : '0;
    end

    // store comparison, sampled mid-cycle
    always @(negedge clock) begin
        if (!rst) begin
            if (storeIdx >= expCount) begin
                // nothing may be stored once the list is used up
                checkBit("dmemWren", dmemWren, 1'b0);
            end else if (dmemWren) begin
                checkWord($sformatf("dmemAddr of store %0d", storeIdx), dmemAddr,
                          expAddr[storeIdx]);
                checkWord($sformatf("dmemWdata of store %0d", storeIdx), dmemWdata,
                          expData[storeIdx]);
                storeIdx++;
            end
        end
    end

    initial begin
        wait (watchLimit > 0);
        repeat (watchLimit) @(posedge clock);
        $display("watchdog expired after %0d cycles with %0d of %0d stores seen",
                 watchLimit, storeIdx, expCount);
        abortRun();
    end

    initial begin
        int executed;
        rst = 1'b1;
        void'($urandom(32'h9a9a_21a0));
        for (int i = 0; i < memWords; i++) begin
            dataMem[i] = fillWord(i);
        end
        buildProgram();
        executed = refRun();
        expCount = expAddr.size();
        // reset plus a drain window on top of the per-instruction budget
        watchLimit = cyclesPerInstr * executed + 30;
        $display("program %0d words, %0d instructions run, %0d stores expected",
                 progLen, executed, expCount);
        repeat (10) @(negedge clock);
        checkWord("imemAddr", imemAddr, bootPc);
        checkBit("dmemWren", dmemWren, 1'b0);
        rst = 1'b0;
        wait (storeIdx == expCount);
        // let the parked jump spin to catch stray strobes
        repeat (20) @(negedge clock);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/cpuPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/executeStage.sv
logic/memWriteback.sv
logic/cpuCore.sv
bench/cpuCore_chk.sv
bench/cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the core testbench with Verilator and runs it
# the exit status is the simulator's own

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
    --top-module cpuTb -f vlog.f \
    --Mdir obj_dir -o cpuTbSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/cpuTbSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
